//--- all.f
source/isa_pkg.sv
source/core_pkg.sv
source/instr_decode.sv
source/reg_inuse.sv
source/reg_file.sv
source/issue_stage.sv
source/alu_pipe.sv
source/int_core_top.sv
dv/tb_clock_gen.sv
dv/int_core_tb.sv

//--- dv/core_input.txt
// Columns: instruction word, expected result value (both hex)
// Illegal encodings expect zero, rd = x0 results still carry the sum
00500093 00000005 // addi x1, x0, 5
ffd00113 fffffffd // addi x2, x0, -3
002081b3 00000002 // add  x3, x1, x2
40208233 00000008 // sub  x4, x1, x2
001122b3 00000001 // slt  x5, x2, x1
0020a333 00000000 // slt  x6, x1, x2
0f014393 ffffff0d // xori x7, x2, 0x0f0
ff00e413 fffffff5 // ori  x8, x1, -16
7ff47493 000007f5 // andi x9, x8, 0x7ff
00747533 ffffff05 // and  x10, x8, x7
0034e5b3 000007f7 // or   x11, x9, x3
00a5c633 fffff8f2 // xor  x12, x11, x10
00208033 00000002 // add  x0, x1, x2
001006b3 00000005 // add  x13, x0, x1
00712093 00000000 // slti x1, x2, 7 (illegal)
02108133 00000000 // mul  x2, x1, x1 (illegal)
40208733 00000008 // sub  x14, x1, x2
ff870793 00000000 // addi x15, x14, -8
00f12833 00000001 // slt  x16, x2, x15
00110113 fffffffe // addi x2, x2, 1
00110113 ffffffff // addi x2, x2, 1
010108b3 00000000 // add  x17, x2, x16

//--- dv/int_core_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the integer issue and writeback slice
// Reads instruction and expected-value pairs, drives them
// with random gaps and back-pressure, checks every result
// against a reference register model kept in program order
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module int_core_tb import isa_pkg::*; import core_pkg::*; ();

    localparam int EXEC_STAGES = 3;
    localparam int MAX_INSTR   = 64;
    localparam int RUN_LIMIT   = 4000;
    localparam int SWEEP_LIMIT = 40;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic        instr_ready;
    instr_word_u instr;
    logic        result_valid;
    logic        result_ready;
    result_t     result;

    // Even entries hold the word, odd entries its expected value
    logic [31:0] vec_mem [0:2*MAX_INSTR-1];
    logic [31:0] ref_regs [32];
    int          pending [$];
    int          n_instr;
    int          mismatches;
    int          other_errors;
    bit          timed_out;

    tb_clock_gen clkgen0 (
        .clk (clk),
        .rst (rst)
    );

    int_core_top #(
        .EXEC_STAGES (EXEC_STAGES)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    function automatic void predict(input logic [31:0] word, output logic [31:0] value,
                                    output reg_addr_t rd, output logic wr, output logic ill);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic [6:0]  f7;
        a     = ref_regs[word[19:15]];
        f3    = word[14:12];
        f7    = word[31:25];
        rd    = word[11:7];
        ill   = 1'b0;
        value = '0;
        // Register-register form
        if (word[6:0] == 7'h33) begin
            b = ref_regs[word[24:20]];
            if (f7 == 7'h20 && f3 == 3'b000)
                value = a - b;
            else if (f7 != 7'h00)
                ill = 1'b1;
            else begin
                case (f3)
                    3'b000:  value = a + b;
                    3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  value = a ^ b;
                    3'b110:  value = a | b;
                    3'b111:  value = a & b;
                    default: ill = 1'b1;
                endcase
            end
        // Register-immediate form, no SLTI
        end else if (word[6:0] == 7'h13) begin
            b = {{20{word[31]}}, word[31:20]};
            case (f3)
                3'b000:  value = a + b;
                3'b100:  value = a ^ b;
                3'b110:  value = a | b;
                3'b111:  value = a & b;
                default: ill = 1'b1;
            endcase
        end else
            ill = 1'b1;
        if (ill)
            value = '0;
        wr = !ill && (rd != 5'd0);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected) else begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Called on a cycle where the result handshake completes
    task automatic check_result();
        int          k;
        logic [31:0] exp_value;
        reg_addr_t   exp_rd;
        logic        exp_wr;
        logic        exp_ill;
        assert (pending.size() != 0) else begin
            other_errors++;
            $display("a result was accepted with no instruction outstanding");
        end
        if (pending.size() != 0) begin
            k = pending.pop_front();
            predict(vec_mem[2*k], exp_value, exp_rd, exp_wr, exp_ill);
            assert (exp_value === vec_mem[2*k+1]) else begin
                other_errors++;
                $display("data file value %h for instruction %0d disagrees with model %h",
                         vec_mem[2*k+1], k, exp_value);
            end
            compare_value("result.value", exp_value, result.value);
            compare_value("result.rd", 32'(exp_rd), 32'(result.rd));
            compare_value("result.writes_rd", 32'(exp_wr), 32'(result.writes_rd));
            compare_value("result.illegal", 32'(exp_ill), 32'(result.illegal));
            if (exp_wr)
                ref_regs[exp_rd] = exp_value;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test phases
    task automatic check_clear_sweep();
        int cycles;
        cycles = 0;
        // rst is stable on the rising edge
        do begin
            @(posedge clk);
            cycles++;
        end while (rst && cycles < 20);
        if (rst) begin
            timed_out = 1'b1;
            other_errors++;
            $display("timeout: reset was never released");
        end else begin
            cycles = 1;
            @(negedge clk);
            while (!instr_ready && cycles <= SWEEP_LIMIT) begin
                assert (!result_valid) else begin
                    other_errors++;
                    $display("result_valid went high during the clear sweep");
                end
                cycles++;
                @(negedge clk);
            end
            if (!instr_ready) begin
                timed_out = 1'b1;
                other_errors++;
                $display("timeout: instr_ready did not rise within %0d cycles", SWEEP_LIMIT);
            end else
                compare_value("instr_ready low cycles", 32'd32, 32'(cycles));
        end
    endtask

    task automatic run_program();
        int      sent;
        int      done;
        int      cycles;
        bit      offering;
        bit      accepted_any;
        bit      held_valid;
        result_t held_res;
        sent         = 0;
        done         = 0;
        cycles       = 0;
        offering     = 1'b0;
        accepted_any = 1'b0;
        held_valid   = 1'b0;
        held_res     = '0;
        while (done < n_instr && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            // Ready low on about a third of cycles
            result_ready = ($urandom_range(2) != 0);
            if (!offering && sent < n_instr)
                offering = ($urandom_range(3) != 0);
            instr_valid = offering;
            if (offering)
                instr = vec_mem[2*sent];
            // Sample after the combinational paths settle, before the edge
            #1;
            if (held_valid) begin
                assert (result_valid) else begin
                    other_errors++;
                    $display("result_valid dropped while result_ready was low");
                end
                assert (result === held_res) else begin
                    mismatches++;
                    $display("mismatch result: expected %h, actual %h", held_res, result);
                end
            end
            assert (accepted_any || !result_valid) else begin
                other_errors++;
                $display("result_valid rose before any instruction was accepted");
            end
            if (instr_valid && instr_ready) begin
                pending.push_back(sent);
                sent++;
                offering     = 1'b0;
                accepted_any = 1'b1;
            end
            if (result_valid && result_ready) begin
                check_result();
                done++;
            end
            held_valid = result_valid && !result_ready;
            held_res   = result;
        end
        if (done < n_instr) begin
            timed_out = 1'b1;
            other_errors++;
            $display("timeout: %0d of %0d results arrived in %0d cycles", done, n_instr, cycles);
        end
    endtask

    // Nothing may follow the last result
    task automatic check_idle();
        @(negedge clk);
        instr_valid  = 1'b0;
        result_ready = 1'b1;
        repeat (2 * EXEC_STAGES + 4) begin
            @(negedge clk);
            assert (!result_valid) else begin
                other_errors++;
                $display("an extra result appeared after the last instruction");
            end
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        instr_valid  = 1'b0;
        instr        = '0;
        result_ready = 1'b0;
        mismatches   = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        void'($urandom(32'hc0a0b27b));
        for (int r = 0; r < 32; r++)
            ref_regs[r] = '0;
        $readmemh("dv/core_input.txt", vec_mem);
        n_instr = 0;
        while (n_instr < MAX_INSTR && !$isunknown(vec_mem[2*n_instr]))
            n_instr++;
        assert (n_instr > 0) else begin
            other_errors++;
            $display("no instructions were read from the data file");
        end
        check_clear_sweep();
        if (!timed_out)
            run_program();
        if (!timed_out)
            check_idle();
        finish_run();
    end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset generator
// 4 ns clock, reset held high for the first rising edges
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release on a falling edge so the DUT sees a clean level
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- source/alu_pipe.sv
////////////////////////////////////////////////////////////
// Pipelined integer ALU
// Computes in the first stage, shifts valid-tagged results
// through EXEC_STAGES registers, last stage is the result port
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module alu_pipe import isa_pkg::*; import core_pkg::*; #(
    parameter int EXEC_STAGES = 3
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        iss_valid,
    output logic        iss_ready,
    input  issue_t      iss,
    output logic        result_valid,
    input  logic        result_ready,
    output result_t     result,
    output logic        wb_en,
    output reg_addr_t   wb_rd,
    output logic [31:0] wb_data,
    output logic        result_done
);

    logic [EXEC_STAGES-1:0] stage_valid;
    result_t                stage_res [EXEC_STAGES];
    result_t                alu_res;
    logic                   advance;
    logic                   handshake;
    logic                   younger_write;

    ////////////////////////////////////////////////////////////
    // ALU
    always_comb begin
        alu_res.rd        = iss.rd;
        alu_res.writes_rd = iss.writes_rd;
        alu_res.illegal   = iss.illegal;
        case (iss.alu_op)
            ALU_ADD: alu_res.value = iss.op_a + iss.op_b;
            ALU_SUB: alu_res.value = iss.op_a - iss.op_b;
            ALU_AND: alu_res.value = iss.op_a & iss.op_b;
            ALU_OR:  alu_res.value = iss.op_a | iss.op_b;
            ALU_XOR: alu_res.value = iss.op_a ^ iss.op_b;
            ALU_SLT: alu_res.value = {31'b0, $signed(iss.op_a) < $signed(iss.op_b)};
            default: alu_res.value = '0;
        endcase
        // Illegal encodings report zero
        if (iss.illegal)
            alu_res.value = '0;
    end

    ////////////////////////////////////////////////////////////
    // Stage registers, whole pipe holds when the last stage is blocked
    assign advance   = ~(stage_valid[EXEC_STAGES-1] & ~result_ready);
    assign iss_ready = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid[0] <= iss_valid;
            for (int k = 1; k < EXEC_STAGES; k++)
                stage_valid[k] <= stage_valid[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            stage_res[0] <= alu_res;
            for (int k = 1; k < EXEC_STAGES; k++)
                stage_res[k] <= stage_res[k-1];
        end
    end

    assign result_valid = stage_valid[EXEC_STAGES-1];
    assign result       = stage_res[EXEC_STAGES-1];

    ////////////////////////////////////////////////////////////
    // Writeback
    assign handshake = result_valid & result_ready;
    assign wb_en     = handshake & result.writes_rd;
    assign wb_rd     = result.rd;
    assign wb_data   = result.value;

    // A younger write to the same register keeps it busy in the scoreboard
    always_comb begin
        younger_write = 1'b0;
        for (int k = 0; k < EXEC_STAGES - 1; k++) begin
            if (stage_valid[k] && stage_res[k].writes_rd && stage_res[k].rd == result.rd)
                younger_write = 1'b1;
        end
    end

    assign result_done = wb_en & ~younger_write;

    ////////////////////////////////////////////////////////////
    // Assertions
    result_hold: assert property (
        @(posedge clk) disable iff (rst)
        (result_valid && !result_ready) |=> (result_valid && $stable(result)));

endmodule

`default_nettype wire

//--- source/core_pkg.sv
////////////////////////////////////////////////////////////
// Core-internal types
// ALU operation codes, decoded instruction, issue packet
// and result record
////////////////////////////////////////////////////////////
`default_nettype none

package core_pkg;
    import isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Output of the decode register
    typedef struct packed {
        alu_op_e     alu_op;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        logic        uses_rs2;
        logic [31:0] imm;
        logic        writes_rd;
        logic        illegal;
    } decoded_t;

    // Operands resolved, ready for the ALU
    typedef struct packed {
        alu_op_e     alu_op;
        logic [31:0] op_a;
        logic [31:0] op_b;
        reg_addr_t   rd;
        logic        writes_rd;
        logic        illegal;
    } issue_t;

    typedef struct packed {
        reg_addr_t   rd;
        logic [31:0] value;
        logic        writes_rd;
        logic        illegal;
    } result_t;

endpackage

`default_nettype wire

//--- source/instr_decode.sv
////////////////////////////////////////////////////////////
// Instruction decode stage
// Splits the word through its R or I view, maps funct fields
// to an ALU operation and holds one decoded entry
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module instr_decode import isa_pkg::*; import core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clearing,
    input  logic        instr_valid,
    output logic        instr_ready,
    input  instr_word_u instr,
    output logic        dec_valid,
    input  logic        dec_ready,
    output decoded_t    dec
);

    decoded_t dec_next;
    logic     entry_valid;
    logic     f7_base;
    logic     f7_sub;

    // Accept while the scoreboard is ready and the entry is free or draining
    assign instr_ready = ~clearing & (~entry_valid | dec_ready);
    assign dec_valid   = entry_valid;

    assign f7_base = (instr.r.funct7 == F7_BASE);
    assign f7_sub  = (instr.r.funct7 == F7_ALT);

    ////////////////////////////////////////////////////////////
    // Field decode
    always_comb begin
        dec_next     = '0;
        dec_next.rs1 = instr.r.rs1;
        dec_next.rd  = instr.r.rd;
        case (instr.r.opcode)
            OP_REG: begin
                dec_next.rs2      = instr.r.rs2;
                dec_next.uses_rs2 = 1'b1;
                case (instr.r.funct3)
                    F3_ADD_SUB: dec_next.alu_op = f7_sub ? ALU_SUB : ALU_ADD;
                    F3_SLT:     dec_next.alu_op = ALU_SLT;
                    F3_XOR:     dec_next.alu_op = ALU_XOR;
                    F3_OR:      dec_next.alu_op = ALU_OR;
                    F3_AND:     dec_next.alu_op = ALU_AND;
                    default:    dec_next.illegal = 1'b1;
                endcase
                // Only ADD/SUB accepts the alternate funct7
                if (!(f7_base || (f7_sub && instr.r.funct3 == F3_ADD_SUB)))
                    dec_next.illegal = 1'b1;
            end
            OP_IMM: begin
                dec_next.rs1 = instr.i.rs1;
                dec_next.rd  = instr.i.rd;
                // Sign-extend the 12-bit immediate
                dec_next.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
                case (instr.i.funct3)
                    F3_ADD_SUB: dec_next.alu_op = ALU_ADD;
                    F3_XOR:     dec_next.alu_op = ALU_XOR;
                    F3_OR:      dec_next.alu_op = ALU_OR;
                    F3_AND:     dec_next.alu_op = ALU_AND;
                    // SLTI and the shifts are not supported
                    default:    dec_next.illegal = 1'b1;
                endcase
            end
            default: dec_next.illegal = 1'b1;
        endcase
        // No architectural write for x0 or illegal encodings
        dec_next.writes_rd = ~dec_next.illegal & (dec_next.rd != '0);
    end

    ////////////////////////////////////////////////////////////
    // One-entry holding register
    always_ff @(posedge clk) begin
        if (rst)
            entry_valid <= 1'b0;
        else if (instr_valid && instr_ready)
            entry_valid <= 1'b1;
        else if (dec_ready)
            entry_valid <= 1'b0;
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (instr_valid && instr_ready)
            dec <= dec_next;
    end

endmodule

`default_nettype wire

//--- source/int_core_top.sv
////////////////////////////////////////////////////////////
// Integer issue and writeback slice, top level
// Decode, issue with scoreboard, pipelined ALU
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module int_core_top import isa_pkg::*; import core_pkg::*; #(
    parameter int EXEC_STAGES = 3
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    output logic        instr_ready,
    input  instr_word_u instr,
    output logic        result_valid,
    input  logic        result_ready,
    output result_t     result
);

    logic        clearing;
    logic        dec_valid;
    logic        dec_ready;
    decoded_t    dec;
    logic        iss_valid;
    logic        iss_ready;
    issue_t      iss;
    logic        wb_en;
    reg_addr_t   wb_rd;
    logic [31:0] wb_data;
    logic        result_done;

    instr_decode decode0 (
        .clk         (clk),
        .rst         (rst),
        .clearing    (clearing),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec         (dec)
    );

    issue_stage issue0 (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec         (dec),
        .iss_valid   (iss_valid),
        .iss_ready   (iss_ready),
        .iss         (iss),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .result_done (result_done),
        .clearing    (clearing)
    );

    alu_pipe #(
        .EXEC_STAGES (EXEC_STAGES)
    ) alu0 (
        .clk          (clk),
        .rst          (rst),
        .iss_valid    (iss_valid),
        .iss_ready    (iss_ready),
        .iss          (iss),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .result_done  (result_done)
    );

endmodule

`default_nettype wire

//--- source/isa_pkg.sv
////////////////////////////////////////////////////////////
// Instruction set definitions for the integer core
// Register index type, opcode and funct constants
// R-type and I-type field maps and the instruction word union
////////////////////////////////////////////////////////////
`default_nettype none

package isa_pkg;

    // Architectural register index, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // Major opcodes handled by this slice
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    // funct3 values, same encoding for register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values, the alternate one only selects SUB
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Register-register field map
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Register-immediate field map
    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // One instruction word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_u;

endpackage

`default_nettype wire

//--- source/issue_stage.sv
////////////////////////////////////////////////////////////
// Issue stage
// Operand read, RAW hazard check against the scoreboard
// and handoff of the issue packet to the ALU pipe
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module issue_stage import isa_pkg::*; import core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        dec_valid,
    output logic        dec_ready,
    input  decoded_t    dec,
    output logic        iss_valid,
    input  logic        iss_ready,
    output issue_t      iss,
    input  logic        wb_en,
    input  reg_addr_t   wb_rd,
    input  logic [31:0] wb_data,
    input  logic        result_done,
    output logic        clearing
);

    logic        rs1_inuse;
    logic        rs2_inuse;
    logic        hazard;
    logic        issued;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    ////////////////////////////////////////////////////////////
    // Scoreboard and register file
    reg_inuse inuse0 (
        .clk            (clk),
        .rst            (rst),
        .rs1_addr       (dec.rs1),
        .rs2_addr       (dec.rs2),
        .decode_rd_addr (dec.rd),
        .wb_rd_addr     (wb_rd),
        .issued         (issued),
        .completed      (result_done),
        .rs1_inuse      (rs1_inuse),
        .rs2_inuse      (rs2_inuse),
        .clearing       (clearing)
    );

    reg_file rf0 (
        .clk      (clk),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    ////////////////////////////////////////////////////////////
    // Hazard check and handshake
    // rs1 is read by every supported format
    assign hazard    = rs1_inuse | (dec.uses_rs2 & rs2_inuse);
    assign iss_valid = dec_valid & ~hazard;
    assign dec_ready = iss_ready & ~hazard;

    // x0 and illegal results never mark a register busy
    assign issued = iss_valid & iss_ready & dec.writes_rd;

    // Issue packet
    assign iss.alu_op    = dec.alu_op;
    assign iss.op_a      = rs1_data;
    assign iss.op_b      = dec.uses_rs2 ? rs2_data : dec.imm;
    assign iss.rd        = dec.rd;
    assign iss.writes_rd = dec.writes_rd;
    assign iss.illegal   = dec.illegal;

    ////////////////////////////////////////////////////////////
    // Assertions
    // A consumer right behind its producer issues only on the producer's writeback
    no_raw_issue: assert property (
        @(posedge clk) disable iff (rst)
        issued |=> !(iss_valid && iss_ready
            && !(result_done && wb_rd == $past(dec.rd))
            && (dec.rs1 == $past(dec.rd)
                || (dec.uses_rs2 && dec.rs2 == $past(dec.rd)))));

endmodule

`default_nettype wire

//--- source/reg_file.sv
////////////////////////////////////////////////////////////
// Integer register file, 32 x 32 bits
// Two asynchronous reads with writeback forwarding, one write
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module reg_file import isa_pkg::*; (
    input  logic        clk,
    input  reg_addr_t   rs1_addr,
    input  reg_addr_t   rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        wb_en,
    input  reg_addr_t   wb_rd,
    input  logic [31:0] wb_data
);

    logic [31:0] regs [32];

    // x0 is hardwired, the writeback value bypasses the array
    function automatic logic [31:0] read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (wb_en && wb_rd == addr)
            return wb_data;
        else
            return regs[addr];
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != '0)
            regs[wb_rd] <= wb_data;
    end

endmodule

`default_nettype wire

//--- source/reg_inuse.sv
////////////////////////////////////////////////////////////
// Register in-use scoreboard
// Issue and writeback toggle banks, one bit per register,
// plus the 32-cycle clear sweep after reset
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module reg_inuse import isa_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t decode_rd_addr,
    input  reg_addr_t wb_rd_addr,
    input  logic      issued,
    input  logic      completed,
    output logic      rs1_inuse,
    output logic      rs2_inuse,
    output logic      clearing
);

    // A register is in use while its two bits differ
    logic      bank_a [32];
    logic      bank_b [32];

    reg_addr_t clear_addr;
    reg_addr_t issue_addr;
    reg_addr_t wb_addr;
    logic      wb_collision;
    logic      rd_inuse;

    ////////////////////////////////////////////////////////////
    // Clear sweep, one address per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            clearing   <= 1'b1;
            clear_addr <= '0;
        end else if (clearing) begin
            clear_addr <= clear_addr + 5'd1;
            if (clear_addr == 5'd31)
                clearing <= 1'b0;
        end
    end

    // Sweep takes over both write ports
    assign issue_addr = clearing ? clear_addr : decode_rd_addr;
    assign wb_addr    = clearing ? clear_addr : wb_rd_addr;

    // Issue to a register whose last write retires this cycle must toggle again
    assign wb_collision = completed && (decode_rd_addr == wb_rd_addr);
    assign rd_inuse     = ~wb_collision & (bank_a[issue_addr] ^ bank_b[issue_addr]);

    // Second issue to a busy register leaves the issue bank alone
    always_ff @(posedge clk) begin
        bank_a[issue_addr] <= clearing | ((issued & ~rd_inuse) ^ bank_a[issue_addr]);
    end

    always_ff @(posedge clk) begin
        bank_b[wb_addr] <= clearing | (completed ^ bank_b[wb_addr]);
    end

    // A source retiring this cycle is already free, the register file forwards it
    assign rs1_inuse = (bank_a[rs1_addr] ^ bank_b[rs1_addr])
                     & ~(completed && wb_rd_addr == rs1_addr);
    assign rs2_inuse = (bank_a[rs2_addr] ^ bank_b[rs2_addr])
                     & ~(completed && wb_rd_addr == rs2_addr);

    ////////////////////////////////////////////////////////////
    // Assertions
    issue_after_clear: assert property (
        @(posedge clk) disable iff (rst) !(issued && clearing));

    // Only the newest write to a register retires it
    complete_inuse: assert property (
        @(posedge clk) disable iff (rst)
        completed |-> (bank_a[wb_rd_addr] ^ bank_b[wb_rd_addr]));

endmodule

`default_nettype wire
